// File: bench/ppu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_tb;

    localparam int SEED            = 29;
    localparam int RESET_CYCLES    = 16;
    localparam int ARITH_OPS       = 200;
    localparam int DIV_OPS         = 50;
    localparam int STALL_OPS       = 20;
    localparam int MIXED_OPS       = 300;
    localparam int TOTAL_OPS       = ARITH_OPS + DIV_OPS + STALL_OPS + MIXED_OPS;
    localparam int WATCHDOG_CYCLES = TOTAL_OPS * 20 + 1000;
    localparam int ALU_LATENCY     = 2;
    localparam int DIV_LATENCY     = 18;
    localparam int DIV_STALL       = 17;

    logic                       clk;
    logic                       rst;
    logic                       valid_i;
    ppu_pkg::op_e               op_i;
    logic [ppu_pkg::DATA_W-1:0] a_i;
    logic [ppu_pkg::DATA_W-1:0] b_i;
    logic                       valid_o;
    logic [ppu_pkg::DATA_W-1:0] result_o;
    logic                       stall_o;

    logic [15:0] lfsr_q;
    int          cyc;
    int          div_t;
    int          errors;
    int          checks;
    int          tests_run;
    int          n_accept;
    int          n_result;
    logic        junk_valid_high;

    // Expected results and their due cycles in acceptance order.
    int                         due_q[$];
    logic [ppu_pkg::DATA_W-1:0] data_q[$];

    ppu_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .valid_i  (valid_i),
        .op_i     (op_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .valid_o  (valid_o),
        .result_o (result_o),
        .stall_o  (stall_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ******************************
    // Helpers and reference model
    // ******************************

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic ppu_pkg::op_e random_op(input logic with_div);
        logic [1:0] r;
        r = 2'(take_bits(2));
        if (!with_div && r == 2'd3) begin
            r = 2'(take_bits(1));
        end
        return ppu_pkg::op_e'(r);
    endfunction

    function automatic logic [15:0] expected_result(input ppu_pkg::op_e op,
                                                    input logic [15:0] a,
                                                    input logic [15:0] b);
        logic [31:0] prod;
        prod = {16'd0, a} * {16'd0, b};
        case (op)
            ppu_pkg::OP_ADD: return 16'(a + b);
            ppu_pkg::OP_SUB: return 16'(a - b);
            ppu_pkg::OP_MUL: return prod[15:0];
            default:         return (b == 16'd0) ? 16'hFFFF : a / b;
        endcase
    endfunction

    // High from one cycle after a divide is accepted through its drain cycle.
    function automatic logic stall_expected(input int c);
        return (c > div_t) && (c <= div_t + DIV_STALL);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int ops, input int err_start);
        tests_run++;
        $display("test %s done: %0d operations, %0d errors", name, ops, errors - err_start);
    endtask

    // ******************************
    // Stimulus
    // ******************************

    task automatic drive_junk();
        valid_i = junk_valid_high ? 1'b1 : 1'(take_bits(1));
        op_i    = random_op(1'b1);
        a_i     = 16'(take_bits(16));
        b_i     = 16'(take_bits(16));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            valid_i = 1'b0;
        end
    endtask

    // Waits out any stall, then presents the operation for one cycle.
    task automatic issue_op(input ppu_pkg::op_e op, input logic [15:0] a,
                            input logic [15:0] b);
        logic done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
            if (stall_expected(cyc)) begin
                drive_junk();
            end else begin
                valid_i = 1'b1;
                op_i    = op;
                a_i     = a;
                b_i     = b;
                done    = 1'b1;
            end
        end
    endtask

    task automatic drain_results();
        // The last operation is queued only at the falling edge of its cycle.
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        while (due_q.size() > 0) begin
            @(posedge clk);
            #1;
            valid_i = 1'b0;
        end
        idle_cycles(4);
        check_value("result count", n_result, n_accept);
    endtask

    task automatic pick_div_operands(output logic [15:0] a, output logic [15:0] b);
        logic [1:0] mode;
        mode = 2'(take_bits(2));
        a    = 16'(take_bits(16));
        case (mode)
            2'd0: b = 16'd0;
            2'd1: b = (a < 16'hFFF0) ? 16'(a + 1 + take_bits(4)) : 16'hFFFF;
            2'd2: b = 16'(take_bits(4));
            default: b = 16'(take_bits(16));
        endcase
    endtask

    // ******************************
    // Monitor
    // ******************************

    // Samples at the falling edge where inputs and outputs have settled.
    always @(negedge clk) begin : monitor
        logic exp_valid;
        while (due_q.size() > 0 && due_q[0] < cyc) begin
            errors++;
            $display("missing result at %0t: operation due in cycle %0d never showed valid_o",
                     $time, due_q[0]);
            void'(due_q.pop_front());
            void'(data_q.pop_front());
        end
        exp_valid = (due_q.size() > 0) && (due_q[0] == cyc);
        check_value("valid_o", valid_o, exp_valid);
        if (exp_valid && valid_o) begin
            check_value("result_o", result_o, data_q[0]);
            n_result++;
            void'(due_q.pop_front());
            void'(data_q.pop_front());
        end
        check_value("stall_o", stall_o, stall_expected(cyc));
        if (!rst && valid_i && !stall_expected(cyc)) begin
            n_accept++;
            data_q.push_back(expected_result(op_i, a_i, b_i));
            if (op_i == ppu_pkg::OP_DIV) begin
                due_q.push_back(cyc + DIV_LATENCY);
                div_t = cyc;
            end else begin
                due_q.push_back(cyc + ALU_LATENCY);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    // ******************************
    // Test sequence
    // ******************************

    initial begin : main
        int          e0;
        logic [15:0] a;
        logic [15:0] b;
        ppu_pkg::op_e op;

        rst             = 1'b1;
        valid_i         = 1'b0;
        op_i            = ppu_pkg::OP_ADD;
        a_i             = '0;
        b_i             = '0;
        lfsr_q          = 16'(SEED);
        cyc             = 0;
        div_t           = -1000;
        errors          = 0;
        checks          = 0;
        tests_run       = 0;
        n_accept        = 0;
        n_result        = 0;
        junk_valid_high = 1'b0;

        e0 = errors;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_cycles(10);
        finish_test("reset", 0, e0);

        e0 = errors;
        for (int i = 0; i < ARITH_OPS; i++) begin
            issue_op(random_op(1'b0), 16'(take_bits(16)), 16'(take_bits(16)));
        end
        drain_results();
        finish_test("arith", ARITH_OPS, e0);

        e0 = errors;
        for (int i = 0; i < DIV_OPS; i++) begin
            pick_div_operands(a, b);
            issue_op(ppu_pkg::OP_DIV, a, b);
        end
        drain_results();
        finish_test("divide", DIV_OPS, e0);

        // Every stalled cycle now carries a valid request that must be ignored.
        e0 = errors;
        junk_valid_high = 1'b1;
        for (int i = 0; i < STALL_OPS; i++) begin
            pick_div_operands(a, b);
            issue_op(ppu_pkg::OP_DIV, a, b);
        end
        drain_results();
        junk_valid_high = 1'b0;
        finish_test("stall", STALL_OPS, e0);

        e0 = errors;
        for (int i = 0; i < MIXED_OPS; i++) begin
            if (take_bits(1)) begin
                idle_cycles(take_bits(2));
            end
            op = random_op(1'b1);
            a  = 16'(take_bits(16));
            b  = 16'(take_bits(16));
            if (op == ppu_pkg::OP_DIV && take_bits(3) == 0) begin
                b = 16'd0;
            end
            issue_op(op, a, b);
        end
        drain_results();
        finish_test("mixed", MIXED_OPS, e0);

        $display("tests: %0d, checks: %0d, accepted: %0d, results: %0d, errors: %0d",
                 tests_run, checks, n_accept, n_result, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ppu_top.f
rtl/ppu_pkg.sv
rtl/ppu_control_unit.sv
rtl/ppu_step_counter.sv
rtl/ppu_divider.sv
rtl/ppu_exec_pipe.sv
rtl/ppu_top.sv
bench/ppu_tb.sv

// File: rtl/ppu_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_control_unit (
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         valid_i,
    input  ppu_pkg::op_e      op_i,
    input  wire logic         last_step_i,
    output logic              issue_alu_o,
    output ppu_pkg::op_e      alu_op_o,
    output logic              start_div_o,
    output logic              div_done_o,
    output logic              stall_o
);

    ppu_pkg::state_e state_q;
    ppu_pkg::state_e state_d;

    logic is_div;

    // Opcode is decoded here only; the pipeline never sees a divide.
    assign is_div = (op_i == ppu_pkg::OP_DIV);

    // ******************************
    // Issue decode
    // ******************************

    always_comb begin
        issue_alu_o = 1'b0;
        start_div_o = 1'b0;
        if (state_q == ppu_pkg::ST_IDLE && valid_i) begin
            issue_alu_o = !is_div;
            start_div_o = is_div;
        end
    end

    assign alu_op_o = issue_alu_o ? op_i : ppu_pkg::OP_ADD;

    // Stall and drain depend on the state register alone.
    assign stall_o    = (state_q != ppu_pkg::ST_IDLE);
    assign div_done_o = (state_q == ppu_pkg::ST_DIV_DRAIN);

    // ******************************
    // State register
    // ******************************

    always_comb begin
        state_d = state_q;
        case (state_q)
            ppu_pkg::ST_IDLE: begin
                if (start_div_o) begin
                    state_d = ppu_pkg::ST_DIV_RUN;
                end
            end
            ppu_pkg::ST_DIV_RUN: begin
                // The counter flags the final iteration.
                if (last_step_i) begin
                    state_d = ppu_pkg::ST_DIV_DRAIN;
                end
            end
            ppu_pkg::ST_DIV_DRAIN: begin
                state_d = ppu_pkg::ST_IDLE;
            end
            default: begin
                state_d = ppu_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ppu_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ******************************
    // Checks
    // ******************************

    // The counter only reports its final step while a divide is running.
    a_last_step_in_run: assert property (
        @(posedge clk) disable iff (rst)
        last_step_i |-> (state_q == ppu_pkg::ST_DIV_RUN)
    );

    // A divide holds the stall for every iteration plus the drain cycle.
    // This relies on the step counter's timing.
    a_div_stall_len: assert property (
        @(posedge clk) disable iff (rst)
        start_div_o |=> stall_o [*ppu_pkg::DIV_STEPS + 1] ##1 !stall_o
    );

endmodule

`default_nettype wire

// File: rtl/ppu_divider.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_divider (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      start_i,
    input  wire logic                      step_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] dividend_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] divisor_i,
    output logic      [ppu_pkg::DATA_W-1:0] quotient_o
);

    localparam int W = ppu_pkg::DATA_W;

    logic [W-1:0] divisor_q;
    logic [W-1:0] rem_q;
    logic [W-1:0] quo_q;

    logic [W:0] shifted;
    logic [W:0] diff;
    logic       fits;

    // ******************************
    // One restoring iteration
    // ******************************

    // The next dividend bit comes out of the top of the quotient register,
    // so the register holds dividend bits on the left and quotient bits
    // on the right as the division proceeds.
    assign shifted = {rem_q, quo_q[W-1]};
    assign diff    = shifted - {1'b0, divisor_q};

    // A zero divisor always fits, which drives every quotient bit to one.
    assign fits = (shifted >= {1'b0, divisor_q});

    // ******************************
    // Registers
    // ******************************

    always_ff @(posedge clk) begin
        if (start_i) begin
            divisor_q <= divisor_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_q <= '0;
            quo_q <= '0;
        end else if (start_i) begin
            rem_q <= '0;
            quo_q <= dividend_i;
        end else if (step_i) begin
            // Remainder stays below a nonzero divisor, so W bits suffice.
            rem_q <= fits ? diff[W-1:0] : shifted[W-1:0];
            quo_q <= {quo_q[W-2:0], fits};
        end
    end

    assign quotient_o = quo_q;

endmodule

`default_nettype wire

// File: rtl/ppu_exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_exec_pipe (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      issue_i,
    input  ppu_pkg::op_e                   op_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] a_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] b_i,
    input  wire logic                      div_done_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] quotient_i,
    output logic                           valid_o,
    output logic      [ppu_pkg::DATA_W-1:0] result_o
);

    localparam int W = ppu_pkg::DATA_W;

    logic         s1_valid_q;
    ppu_pkg::op_e s1_op_q;
    logic [W-1:0] s1_a_q;
    logic [W-1:0] s1_b_q;

    logic [W-1:0] alu_res;

    logic         wb_valid_q;
    logic [W-1:0] wb_data_q;

    // ******************************
    // Stage 1: operand capture
    // ******************************

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            s1_op_q <= op_i;
            s1_a_q  <= a_i;
            s1_b_q  <= b_i;
        end
    end

    // ******************************
    // Stage 2: compute and writeback
    // ******************************

    // All results wrap to W bits; the multiply keeps the low half.
    always_comb begin
        case (s1_op_q)
            ppu_pkg::OP_SUB: alu_res = s1_a_q - s1_b_q;
            ppu_pkg::OP_MUL: alu_res = s1_a_q * s1_b_q;
            default:         alu_res = s1_a_q + s1_b_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= s1_valid_q || div_done_i;
        end
    end

    // The quotient shares this register with the ALU result.
    always_ff @(posedge clk) begin
        if (div_done_i) begin
            wb_data_q <= quotient_i;
        end else if (s1_valid_q) begin
            wb_data_q <= alu_res;
        end
    end

    assign valid_o  = wb_valid_q;
    assign result_o = wb_data_q;

    // The controller's stall must keep the ALU stream and the divide drain
    // from reaching the writeback register in the same cycle.
    a_wb_no_collision: assert property (
        @(posedge clk) disable iff (rst)
        !(s1_valid_q && div_done_i)
    );

endmodule

`default_nettype wire

// File: rtl/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

    // ******************************
    // Widths and step counts
    // ******************************

    // Operand and result width.
    localparam int DATA_W = 16;

    // The restoring divider retires one quotient bit per iteration.
    localparam int DIV_STEPS = DATA_W;

    // Wide enough to hold DIV_STEPS itself.
    localparam int CNT_W = 5;

    // ******************************
    // Encodings
    // ******************************

    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2,
        OP_DIV = 2'd3
    } op_e;

    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_DIV_RUN   = 2'd1,
        ST_DIV_DRAIN = 2'd2
    } state_e;

endpackage

`default_nettype wire

// File: rtl/ppu_step_counter.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_step_counter (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start_i,
    output logic      busy_o,
    output logic      last_step_o
);

    localparam logic [ppu_pkg::CNT_W-1:0] LOAD_VAL = ppu_pkg::CNT_W'(ppu_pkg::DIV_STEPS);
    localparam logic [ppu_pkg::CNT_W-1:0] ONE      = ppu_pkg::CNT_W'(1);

    logic [ppu_pkg::CNT_W-1:0] cnt_q;

    // ******************************
    // Down counter
    // ******************************

    // Loaded in the acceptance cycle, then one decrement per iteration.
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (start_i) begin
            cnt_q <= LOAD_VAL;
        end else if (busy_o) begin
            cnt_q <= cnt_q - ONE;
        end
    end

    // The divider steps in every cycle where the count is nonzero.
    assign busy_o = (cnt_q != '0);

    // Count of one marks the final run cycle.
    assign last_step_o = (cnt_q == ONE);

endmodule

`default_nettype wire

// File: rtl/ppu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
    input  wire logic                      clk,
    input  wire logic                      rst,
    input  wire logic                      valid_i,
    input  ppu_pkg::op_e                   op_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] a_i,
    input  wire logic [ppu_pkg::DATA_W-1:0] b_i,
    output logic                           valid_o,
    output logic      [ppu_pkg::DATA_W-1:0] result_o,
    output logic                           stall_o
);

    logic                      issue_alu;
    ppu_pkg::op_e              alu_op;
    logic                      start_div;
    logic                      div_done;
    logic                      last_step;
    logic                      div_busy;
    logic [ppu_pkg::DATA_W-1:0] quotient;

    // ******************************
    // Control
    // ******************************

    ppu_control_unit u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .last_step_i (last_step),
        .issue_alu_o (issue_alu),
        .alu_op_o    (alu_op),
        .start_div_o (start_div),
        .div_done_o  (div_done),
        .stall_o     (stall_o)
    );

    ppu_step_counter u_cnt (
        .clk         (clk),
        .rst         (rst),
        .start_i     (start_div),
        .busy_o      (div_busy),
        .last_step_o (last_step)
    );

    // ******************************
    // Datapath
    // ******************************

    // The divider iterates for exactly as long as the counter is busy.
    ppu_divider u_div (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_div),
        .step_i     (div_busy),
        .dividend_i (a_i),
        .divisor_i  (b_i),
        .quotient_o (quotient)
    );

    ppu_exec_pipe u_pipe (
        .clk        (clk),
        .rst        (rst),
        .issue_i    (issue_alu),
        .op_i       (alu_op),
        .a_i        (a_i),
        .b_i        (b_i),
        .div_done_i (div_done),
        .quotient_i (quotient),
        .valid_o    (valid_o),
        .result_o   (result_o)
    );

endmodule

`default_nettype wire
